/* common/dazzler_pkg.sv */
`default_nettype none

package dazzler_pkg;

  ////////////////////
  // sizes

  localparam int N_WII       = 2;   // controller channels
  localparam int IO_ADDR_W   = 12;  // decoded address bits
  localparam int WII_SLICES  = 3;   // 16-bit write slices per report
  localparam int REPORT_BITS = 48;
  localparam int SNAP_BITS   = 2 * REPORT_BITS * N_WII;

  ////////////////////
  // io address map

  localparam logic [IO_ADDR_W-1:0] ADDR_WII_BASE    = 12'h004;
  localparam logic [IO_ADDR_W-1:0] ADDR_SYSCTL      = 12'h014;
  localparam logic [IO_ADDR_W-1:0] ADDR_TICKS       = 12'h015;
  localparam logic [IO_ADDR_W-1:0] ADDR_SPI_PINS    = 12'h100;
  localparam logic [IO_ADDR_W-1:0] ADDR_SPI_START8  = 12'h101;
  localparam logic [IO_ADDR_W-1:0] ADDR_SPI_START16 = 12'h102;
  localparam logic [IO_ADDR_W-1:0] ADDR_SPI_IDLE    = 12'h103;

  ////////////////////
  // bus and pins

  // one cpu bus cycle
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [15:0] addr;
    logic [15:0] wdata;
  } io_req_t;

  typedef struct packed {
    logic cs;
    logic sck;
    logic mosi;
  } spi_pins_t;

  ////////////////////
  // wii classic report

  // bit groups are scattered over the first four bytes
  typedef struct packed {
    logic [15:0] rsvd;
    logic [2:0]  lt_20;   // byte 3
    logic [4:0]  rt;
    logic        rx_0;    // byte 2
    logic [1:0]  lt_43;
    logic [4:0]  ry;
    logic [1:0]  rx_21;   // byte 1
    logic [5:0]  ly;
    logic [1:0]  rx_43;   // byte 0
    logic [5:0]  lx;
  } wii_raw_fields_t;

  typedef union packed {
    logic [5:0][7:0] bytes;
    wii_raw_fields_t f;
  } wii_report_u;

  // lx sits in the lowest byte
  typedef struct packed {
    logic [7:0] rt;
    logic [7:0] lt;
    logic [7:0] ry;
    logic [7:0] rx;
    logic [7:0] ly;
    logic [7:0] lx;
  } wii_decoded_t;

endpackage

`default_nettype wire

/* source/io_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module io_regs import dazzler_pkg::*; (
  input  wire logic                      clk50,
  input  wire logic                      SCKclock,
  input  wire io_req_t                   io_req_i,
  input  wire logic [15:0]               spi_rx_i,
  input  wire logic                      spi_idle_i,
  input  wire logic                      spi_miso_i,
  output logic [15:0]                    io_rdata_o,
  output logic [WII_SLICES*N_WII-1:0]    wii_we_o,
  output logic [15:0]                    wdata_o,
  output logic                           spi_start8_o,
  output logic                           spi_start16_o,
  output logic                           spi_pins_we_o,
  output logic                           pd_o
);

  logic [IO_ADDR_W-1:0] addr_lo;
  logic                 wr_en;
  logic                 rd_en;
  logic [15:0]          sysctl_q;
  logic [15:0]          ticks_q;
  logic [15:0]          rd_word;
  logic [15:0]          rdata_q;

  assign addr_lo = io_req_i.addr[IO_ADDR_W-1:0];
  assign wr_en   = io_req_i.wr;
  assign rd_en   = io_req_i.rd;

  ////////////////////
  // write decode

  assign wdata_o       = io_req_i.wdata;
  assign spi_start8_o  = wr_en && (addr_lo == ADDR_SPI_START8);
  assign spi_start16_o = wr_en && (addr_lo == ADDR_SPI_START16);
  assign spi_pins_we_o = wr_en && (addr_lo == ADDR_SPI_PINS);

  // three slice strobes per channel, consecutive addresses
  always_comb begin
    for (int c = 0; c < N_WII; c++) begin
      for (int s = 0; s < WII_SLICES; s++) begin
        wii_we_o[WII_SLICES*c+s] = wr_en &&
          (addr_lo == ADDR_WII_BASE + IO_ADDR_W'(WII_SLICES*c + s));
      end
    end
  end

  ////////////////////
  // control registers

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      sysctl_q <= '0;
    end else if (wr_en && (addr_lo == ADDR_SYSCTL)) begin
      sysctl_q <= io_req_i.wdata;
    end
  end

  assign pd_o = sysctl_q[0];  // display power-down

  // free running, wraps
  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      ticks_q <= '0;
    end else begin
      ticks_q <= ticks_q + 16'd1;
    end
  end

  ////////////////////
  // read back

  always_comb begin
    case (addr_lo)
      ADDR_SYSCTL:      rd_word = sysctl_q;
      ADDR_TICKS:       rd_word = ticks_q;
      ADDR_SPI_PINS:    rd_word = {14'd0, spi_miso_i, 1'b0};
      ADDR_SPI_START8,
      ADDR_SPI_START16: rd_word = spi_rx_i;
      ADDR_SPI_IDLE:    rd_word = {15'd0, spi_idle_i};
      default:          rd_word = '0;
    endcase
  end

  // held until the next read
  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  assign io_rdata_o = rdata_q;

  // cpu issues at most one strobe per cycle
  a_one_strobe: assert property (
    @(posedge clk50) disable iff (SCKclock) !(io_req_i.rd && io_req_i.wr)
  );

endmodule

`default_nettype wire

/* spi/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master import dazzler_pkg::*; (
  input  wire logic        clk50,
  input  wire logic        SCKclock,
  input  wire logic        start8_i,
  input  wire logic        start16_i,
  input  wire logic        pins_we_i,
  input  wire logic [15:0] tx_i,
  input  wire logic        miso_i,
  output logic [15:0]      rx_o,
  output logic             idle_o,
  output spi_pins_t        pins_o
);

  logic        running_q;
  logic [4:0]  cnt_q;
  logic [15:0] shift_q;
  logic [15:0] tx_swapped;
  spi_pins_t   bb_q;

  // first byte on the wire is the low byte
  assign tx_swapped = {tx_i[7:0], tx_i[15:8]};

  ////////////////////
  // shift engine

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
    end else if (start8_i) begin
      running_q <= 1'b1;
      cnt_q     <= 5'd16;  // half the count for one byte
    end else if (start16_i) begin
      running_q <= 1'b1;
      cnt_q     <= 5'd0;
    end else if (running_q) begin
      running_q <= (cnt_q != 5'd31);
      cnt_q     <= cnt_q + 5'd1;  // wraps to 0 after 31
    end
  end

  always_ff @(posedge clk50) begin
    if (start8_i || start16_i) begin
      shift_q <= tx_swapped;
    end else if (running_q && cnt_q[0]) begin
      shift_q <= {shift_q[14:0], miso_i};  // sample while sck high
    end
  end

  assign rx_o   = shift_q;
  assign idle_o = ~running_q;

  ////////////////////
  // bit-bang pins

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      bb_q <= '0;
    end else if (pins_we_i) begin
      bb_q <= '{cs: tx_i[5], sck: tx_i[4], mosi: tx_i[0]};
    end
  end

  assign pins_o.cs   = bb_q.cs;
  assign pins_o.sck  = bb_q.sck | cnt_q[0];
  assign pins_o.mosi = bb_q.mosi | (running_q & shift_q[15]);

  // a finished transfer always parks the counter at zero
  a_idle_parked: assert property (
    @(posedge clk50) disable iff (SCKclock) !running_q |-> (cnt_q == 5'd0)
  );

endmodule

`default_nettype wire

/* wii/wii_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module wii_channel import dazzler_pkg::*; (
  input  wire logic                  clk50,
  input  wire logic                  SCKclock,
  input  wire logic [WII_SLICES-1:0] we_i,
  input  wire logic [15:0]           wdata_i,
  output wii_report_u                raw_o,
  output wii_decoded_t               decoded_o
);

  wii_report_u rpt_q;

  // one 16-bit slice per strobe
  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      rpt_q <= '0;
    end else begin
      for (int s = 0; s < WII_SLICES; s++) begin
        if (we_i[s]) begin
          rpt_q.bytes[2*s +: 2] <= wdata_i;
        end
      end
    end
  end

  assign raw_o = rpt_q;

  ////////////////////
  // field decode

  always_comb begin
    decoded_o.lx = {2'b00, rpt_q.f.lx};
    decoded_o.ly = {2'b00, rpt_q.f.ly};
    // right stick x is spread over three bytes
    decoded_o.rx = {3'b000, rpt_q.f.rx_43, rpt_q.f.rx_21, rpt_q.f.rx_0};
    decoded_o.ry = {3'b000, rpt_q.f.ry};
    decoded_o.lt = {3'b000, rpt_q.f.lt_43, rpt_q.f.lt_20};
    decoded_o.rt = {3'b000, rpt_q.f.rt};
  end

endmodule

`default_nettype wire

/* wii/wii_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module wii_readout import dazzler_pkg::*; (
  input  wire logic                      clk50,
  input  wire logic                      SCKclock,
  input  wire wii_report_u  [N_WII-1:0]  raw_i,
  input  wire wii_decoded_t [N_WII-1:0]  decoded_i,
  input  wire logic                      host_sel_n_i,
  input  wire logic                      host_sck_i,
  output logic                           host_miso_o
);

  logic [1:0]           sel_sync_q;
  logic [2:0]           sck_sync_q;  // bit 2 is the previous level
  logic                 selected;
  logic                 sck_rise;
  logic [SNAP_BITS-1:0] snap_w;
  logic [SNAP_BITS-1:0] snap_q;
  logic [7:0]           idx_q;

  ////////////////////
  // host pin sync

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      sel_sync_q <= 2'b11;
      sck_sync_q <= '0;
    end else begin
      sel_sync_q <= {sel_sync_q[0], host_sel_n_i};
      sck_sync_q <= {sck_sync_q[1:0], host_sck_i};
    end
  end

  assign selected = ~sel_sync_q[1];
  assign sck_rise = sck_sync_q[1] & ~sck_sync_q[2];

  ////////////////////
  // snapshot

  // per channel raw then decoded, from bit 0 up
  always_comb begin
    for (int c = 0; c < N_WII; c++) begin
      snap_w[2*REPORT_BITS*c +: REPORT_BITS]             = raw_i[c];
      snap_w[2*REPORT_BITS*c + REPORT_BITS +: REPORT_BITS] = decoded_i[c];
    end
  end

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      snap_q <= '0;
      idx_q  <= '0;
    end else if (!selected) begin
      snap_q <= snap_w;  // reload while host idle
      idx_q  <= '0;
    end else if (sck_rise) begin
      if (idx_q == 8'(SNAP_BITS - 1)) begin
        idx_q <= '0;
      end else begin
        idx_q <= idx_q + 8'd1;
      end
    end
  end

  // lowest byte first, msb first within each byte
  assign host_miso_o = snap_q[{idx_q[7:3], ~idx_q[2:0]}];

  a_idx_range: assert property (
    @(posedge clk50) disable iff (SCKclock) selected |-> (idx_q < SNAP_BITS)
  );

endmodule

`default_nettype wire

/* source/dazzler_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dazzler_io_top import dazzler_pkg::*; (
  input  wire logic    clk50,
  input  wire logic    SCKclock,
  input  wire io_req_t io_req_i,
  input  wire logic    spi_miso_i,
  input  wire logic    host_sel_n_i,
  input  wire logic    host_sck_i,
  output logic [15:0]  io_rdata_o,
  output spi_pins_t    spi_pins_o,
  output logic         pd_o,
  output logic         host_miso_o
);

  logic [WII_SLICES*N_WII-1:0] wii_we;
  logic [15:0]                 wdata;
  logic                        spi_start8;
  logic                        spi_start16;
  logic                        spi_pins_we;
  logic [15:0]                 spi_rx;
  logic                        spi_idle;
  wii_report_u  [N_WII-1:0]    wii_raw;
  wii_decoded_t [N_WII-1:0]    wii_dec;

  io_regs u_io_regs (
    .clk50         (clk50),
    .SCKclock      (SCKclock),
    .io_req_i      (io_req_i),
    .spi_rx_i      (spi_rx),
    .spi_idle_i    (spi_idle),
    .spi_miso_i    (spi_miso_i),
    .io_rdata_o    (io_rdata_o),
    .wii_we_o      (wii_we),
    .wdata_o       (wdata),
    .spi_start8_o  (spi_start8),
    .spi_start16_o (spi_start16),
    .spi_pins_we_o (spi_pins_we),
    .pd_o          (pd_o)
  );

  spi_master u_spi (
    .clk50     (clk50),
    .SCKclock  (SCKclock),
    .start8_i  (spi_start8),
    .start16_i (spi_start16),
    .pins_we_i (spi_pins_we),
    .tx_i      (wdata),
    .miso_i    (spi_miso_i),
    .rx_o      (spi_rx),
    .idle_o    (spi_idle),
    .pins_o    (spi_pins_o)
  );

  ////////////////////
  // controller channels

  for (genvar g = 0; g < N_WII; g++) begin : g_wii
    wii_channel u_chan (
      .clk50     (clk50),
      .SCKclock  (SCKclock),
      .we_i      (wii_we[WII_SLICES*g +: WII_SLICES]),
      .wdata_i   (wdata),
      .raw_o     (wii_raw[g]),
      .decoded_o (wii_dec[g])
    );
  end

  wii_readout u_readout (
    .clk50        (clk50),
    .SCKclock     (SCKclock),
    .raw_i        (wii_raw),
    .decoded_i    (wii_dec),
    .host_sel_n_i (host_sel_n_i),
    .host_sck_i   (host_sck_i),
    .host_miso_o  (host_miso_o)
  );

endmodule

`default_nettype wire

/* verification/tb_dazzler_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dazzler_io import dazzler_pkg::*; ();

  localparam logic [3:0]  K_WR   = 4'd0;
  localparam logic [3:0]  K_RD   = 4'd1;
  localparam logic [3:0]  K_POLL = 4'd2;  // read until masked value matches
  localparam logic [3:0]  K_PINS = 4'd3;
  localparam logic [3:0]  K_PD   = 4'd4;
  localparam logic [3:0]  K_MISO = 4'd5;
  localparam int          POLL_LIMIT = 64;
  localparam logic [31:0] LFSR_SEED  = 32'h70cb17ef;

  typedef struct packed {
    logic [3:0]  kind;
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] exp;
    logic [15:0] mask;
  } row_t;

  logic        clk50;
  logic        SCKclock;
  io_req_t     io_req;
  logic        spi_miso;
  logic        host_sel_n;
  logic        host_sck;
  logic [15:0] io_rdata;
  spi_pins_t   spi_pins;
  logic        pd;
  logic        host_miso;

  row_t        rows[$];
  logic [31:0] lfsr_q;
  int          mismatches;
  int          timeouts;

  dazzler_io_top u_dazzler_io_top (
    .clk50        (clk50),
    .SCKclock     (SCKclock),
    .io_req_i     (io_req),
    .spi_miso_i   (spi_miso),
    .host_sel_n_i (host_sel_n),
    .host_sck_i   (host_sck),
    .io_rdata_o   (io_rdata),
    .spi_pins_o   (spi_pins),
    .pd_o         (pd),
    .host_miso_o  (host_miso)
  );

  always #50 clk50 = ~clk50;

  // mosi looped back to miso
  always @(negedge clk50) begin
    spi_miso <= spi_pins.mosi;
  end

  ////////////////////
  // helpers

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // controller fields from the first four report bytes
  function automatic logic [47:0] decode_report(input logic [47:0] r);
    logic [7:0] b0, b1, b2, b3;
    logic [7:0] lx, ly, rx, ry, lt, rt;
    b0 = r[7:0];
    b1 = r[15:8];
    b2 = r[23:16];
    b3 = r[31:24];
    lx = {2'b00, b0[5:0]};
    ly = {2'b00, b1[5:0]};
    rx = {3'b000, b0[7:6], b1[7:6], b2[7]};
    ry = {3'b000, b2[4:0]};
    lt = {3'b000, b2[6:5], b3[7:5]};
    rt = {3'b000, b3[4:0]};
    decode_report = {rt, lt, ry, rx, ly, lx};
  endfunction

  task automatic check_value(input string what, input logic [15:0] addr,
                             input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH time %0t: %s at addr %h, got %h expected %h",
               $time, what, addr, got, exp);
    end
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
    io_req = '{rd: 1'b0, wr: 1'b1, addr: addr, wdata: data};
    @(posedge clk50);
    @(negedge clk50);
    io_req = '0;
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
    io_req = '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: 16'h0000};
    @(posedge clk50);
    @(negedge clk50);
    io_req = '0;
    data   = io_rdata;  // registered, stable here
  endtask

  task automatic add_row(input logic [3:0] kind, input logic [15:0] addr,
                         input logic [15:0] data, input logic [15:0] exp,
                         input logic [15:0] mask);
    row_t r;
    r.kind = kind;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    r.mask = mask;
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    logic [15:0] rd;
    int          n;
    case (r.kind)
      K_WR: bus_write(r.addr, r.data);
      K_RD: begin
        bus_read(r.addr, rd);
        check_value("read", r.addr, rd & r.mask, r.exp);
      end
      K_POLL: begin
        n = 1;
        bus_read(r.addr, rd);
        while (((rd & r.mask) !== r.exp) && (n < POLL_LIMIT)) begin
          bus_read(r.addr, rd);
          n++;
        end
        if ((rd & r.mask) !== r.exp) begin
          timeouts++;
          $display("timeout: address %h did not reach %h within %0d reads",
                   r.addr, r.exp, POLL_LIMIT);
        end
      end
      K_PINS: check_value("spi pins", r.addr, {13'd0, spi_pins}, r.exp);
      K_PD:   check_value("pd pin", r.addr, {15'd0, pd}, r.exp);
      K_MISO: check_value("host miso", r.addr, {15'd0, host_miso}, r.exp);
      default: begin
        mismatches++;
        $display("unknown table row kind %0d", r.kind);
      end
    endcase
  endtask

  task automatic check_ticks(input int k);
    logic [15:0] t0;
    logic [15:0] t1;
    bus_read(16'(ADDR_TICKS), t0);
    repeat (k - 1) @(negedge clk50);
    bus_read(16'(ADDR_TICKS), t1);
    check_value("tick delta", 16'(ADDR_TICKS), t1 - t0, 16'(k));
  endtask

  task automatic load_wii(output logic [SNAP_BITS-1:0] snap);
    logic [15:0] word;
    logic [47:0] raw;
    snap = '0;
    for (int c = 0; c < N_WII; c++) begin
      raw = '0;
      for (int s = 0; s < 3; s++) begin
        take_bits(16, word);
        bus_write(16'(ADDR_WII_BASE) + 16'(3 * c + s), word);
        raw[16*s +: 16] = word;
      end
      snap[96*c +: 48]      = raw;
      snap[96*c + 48 +: 48] = decode_report(raw);
    end
  endtask

  // host holds each sck level four cycles
  task automatic run_readout(input logic [SNAP_BITS-1:0] snap);
    int pos;
    repeat (4) @(negedge clk50);
    host_sel_n = 1'b0;
    repeat (4) @(negedge clk50);
    for (int k = 0; k < SNAP_BITS; k++) begin
      pos = 8 * (k / 8) + 7 - (k % 8);  // byte order up, msb first
      if (host_miso !== snap[pos]) begin
        mismatches++;
        $display("MISMATCH time %0t: readout bit %0d got %b expected %b",
                 $time, k, host_miso, snap[pos]);
      end
      host_sck = 1'b1;
      repeat (4) @(negedge clk50);
      host_sck = 1'b0;
      repeat (4) @(negedge clk50);
    end
    host_sel_n = 1'b1;
    repeat (4) @(negedge clk50);
  endtask

  ////////////////////
  // main sequence

  initial begin : main
    logic [SNAP_BITS-1:0] snap;
    clk50      = 1'b0;
    SCKclock   = 1'b1;
    io_req     = '0;
    spi_miso   = 1'b0;
    host_sel_n = 1'b1;
    host_sck   = 1'b0;
    lfsr_q     = LFSR_SEED;
    mismatches = 0;
    timeouts   = 0;

    // reset state
    add_row(K_RD,   16'(ADDR_SYSCTL),      16'h0000, 16'h0000, 16'hffff);
    add_row(K_RD,   16'(ADDR_SPI_IDLE),    16'h0000, 16'h0001, 16'hffff);
    add_row(K_PD,   16'h0000,              16'h0000, 16'h0000, 16'hffff);
    add_row(K_PINS, 16'h0000,              16'h0000, 16'h0000, 16'hffff);
    add_row(K_MISO, 16'h0000,              16'h0000, 16'h0000, 16'hffff);
    // sysctl
    add_row(K_WR,   16'(ADDR_SYSCTL),      16'h1235, 16'h0000, 16'hffff);
    add_row(K_RD,   16'(ADDR_SYSCTL),      16'h0000, 16'h1235, 16'hffff);
    add_row(K_PD,   16'h0000,              16'h0000, 16'h0001, 16'hffff);
    add_row(K_WR,   16'(ADDR_SYSCTL),      16'ha5a4, 16'h0000, 16'hffff);
    add_row(K_RD,   16'(ADDR_SYSCTL),      16'h0000, 16'ha5a4, 16'hffff);
    add_row(K_PD,   16'h0000,              16'h0000, 16'h0000, 16'hffff);
    add_row(K_RD,   16'h7014,              16'h0000, 16'ha5a4, 16'hffff);
    add_row(K_RD,   16'h0200,              16'h0000, 16'h0000, 16'hffff);
    // spi byte and word transfers
    add_row(K_WR,   16'(ADDR_SPI_START8),  16'h3c5a, 16'h0000, 16'hffff);
    add_row(K_RD,   16'(ADDR_SPI_IDLE),    16'h0000, 16'h0000, 16'hffff);
    add_row(K_POLL, 16'(ADDR_SPI_IDLE),    16'h0000, 16'h0001, 16'h0001);
    add_row(K_RD,   16'(ADDR_SPI_START8),  16'h0000, 16'h005a, 16'h00ff);
    add_row(K_WR,   16'(ADDR_SPI_START16), 16'hc3a5, 16'h0000, 16'hffff);
    add_row(K_RD,   16'(ADDR_SPI_IDLE),    16'h0000, 16'h0000, 16'hffff);
    add_row(K_POLL, 16'(ADDR_SPI_IDLE),    16'h0000, 16'h0001, 16'h0001);
    add_row(K_RD,   16'(ADDR_SPI_START16), 16'h0000, 16'ha5c3, 16'hffff);
    add_row(K_WR,   16'(ADDR_SPI_START16), 16'h1e81, 16'h0000, 16'hffff);
    add_row(K_POLL, 16'(ADDR_SPI_IDLE),    16'h0000, 16'h0001, 16'h0001);
    add_row(K_RD,   16'(ADDR_SPI_START8),  16'h0000, 16'h811e, 16'hffff);
    // bit-bang pins, {cs, sck, mosi}
    add_row(K_WR,   16'(ADDR_SPI_PINS),    16'h0031, 16'h0000, 16'hffff);
    add_row(K_PINS, 16'h0000,              16'h0000, 16'h0007, 16'hffff);
    add_row(K_RD,   16'(ADDR_SPI_PINS),    16'h0000, 16'h0002, 16'hffff);
    add_row(K_WR,   16'(ADDR_SPI_PINS),    16'h0020, 16'h0000, 16'hffff);
    add_row(K_PINS, 16'h0000,              16'h0000, 16'h0004, 16'hffff);
    add_row(K_RD,   16'(ADDR_SPI_PINS),    16'h0000, 16'h0000, 16'hffff);
    add_row(K_WR,   16'(ADDR_SPI_PINS),    16'h0001, 16'h0000, 16'hffff);
    add_row(K_PINS, 16'h0000,              16'h0000, 16'h0001, 16'hffff);
    add_row(K_RD,   16'(ADDR_SPI_PINS),    16'h0000, 16'h0002, 16'hffff);
    add_row(K_WR,   16'(ADDR_SPI_PINS),    16'h0000, 16'h0000, 16'hffff);
    add_row(K_PINS, 16'h0000,              16'h0000, 16'h0000, 16'hffff);

    repeat (4) @(negedge clk50);
    SCKclock = 1'b0;
    @(negedge clk50);

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    check_ticks(1);
    check_ticks(5);
    check_ticks(17);

    // two rounds so the snapshot reload is exercised too
    for (int r = 0; r < 2; r++) begin
      load_wii(snap);
      run_readout(snap);
    end

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
common/dazzler_pkg.sv
source/io_regs.sv
spi/spi_master.sv
wii/wii_channel.sv
wii/wii_readout.sv
source/dazzler_io_top.sv
verification/tb_dazzler_io.sv
